// ==== Bender.yml ====
package:
  name: bomb_field

sources:
  - rtl/bomb_pkg.sv
  - rtl/bomb_logic.sv
  - rtl/map_write_arbiter.sv
  - rtl/map_mem.sv
  - rtl/bomb_field.sv
  - target: simulation
    files:
      - bench/bomb_field_tb.sv

// ==== bench/bomb_field_tb.sv ====
`timescale 1ns/1ps

module bomb_field_tb;
  import bomb_pkg::*;

  localparam int NUM_ROW       = 11;
  localparam int NUM_COL       = 19;
  localparam int TILE_PX       = 64;
  localparam int SPRITE_W      = 32;
  localparam int SPRITE_H      = 64;
  localparam int BOMB_TIME     = 3;
  localparam int TICKS_PER_SEC = 4;  // short fuse, short run
  localparam int DEPTH         = NUM_ROW * NUM_COL;
  localparam int FUSE_W        = $clog2(BOMB_TIME + 1);
  localparam int FUSE_TICKS    = BOMB_TIME * TICKS_PER_SEC;
  localparam int X_SPAN        = NUM_COL * TILE_PX - SPRITE_W + 1;  // sprite stays on the map
  localparam int Y_SPAN        = NUM_ROW * TILE_PX - SPRITE_H + 1;
  localparam int N_RAND        = 8;
  // worst case cycles per step, summed over the test list below
  localparam int SCAN_CYC      = 2 * DEPTH + 2;
  localparam int FUSE_CYC      = 6 * (FUSE_TICKS + 4);
  localparam int PLACE_CYC     = 10;
  localparam int LIMIT         = 2 * (15 * SCAN_CYC + 13 * FUSE_CYC + 24 * PLACE_CYC);

  logic              clk;
  logic              arst_n;
  logic              tick;
  logic              game_over;
  logic [1:0]        place_bomb;
  px_x_t             p0_x;
  px_x_t             p1_x;
  px_y_t             p0_y;
  px_y_t             p1_y;
  map_addr_t         read_addr;
  tile_t             read_data;
  logic [1:0]        explode;
  logic [1:0]        busy;
  logic [FUSE_W-1:0] p0_fuse_left;
  logic [FUSE_W-1:0] p1_fuse_left;

  integer      seed;
  int          tests, checks, errors, err_mark, cycles;
  int          d_expl [2];    // explode pulses seen on the DUT
  int          exp_expl [2];  // explode pulses owed by the tests
  px_x_t       pos_x [2];     // positions last driven
  px_y_t       pos_y [2];
  // model of both players and the map
  bomb_state_t m_st [2];
  int          m_ticks [2];
  map_addr_t   m_addr [2];
  logic [1:0]  m_prev;
  logic [1:0]  m_rise1;
  logic [1:0]  m_rise2;
  tile_t       m_tile [DEPTH];

  bomb_field #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .TILE_PX(TILE_PX), .SPRITE_W(SPRITE_W),
    .SPRITE_H(SPRITE_H), .BOMB_TIME(BOMB_TIME), .TICKS_PER_SEC(TICKS_PER_SEC)
  ) DUT (
    .clk(clk), .arst_n(arst_n), .tick(tick), .game_over(game_over),
    .place_bomb(place_bomb), .p0_x(p0_x), .p1_x(p1_x), .p0_y(p0_y), .p1_y(p1_y),
    .read_addr(read_addr), .read_data(read_data), .explode(explode), .busy(busy),
    .p0_fuse_left(p0_fuse_left), .p1_fuse_left(p1_fuse_left)
  );

  always #5 clk = ~clk;

  // tile under the sprite centre
  function automatic map_addr_t tile_of(input px_x_t x, input px_y_t y);
    int col;
    int row;
    col = (int'(x) + SPRITE_W / 2) / TILE_PX;
    row = (int'(y) + SPRITE_H / 2) / TILE_PX;
    return map_addr_t'(row * NUM_COL + col);
  endfunction

  // whole seconds still to burn, rounded up, zero outside the countdown
  function automatic logic [FUSE_W-1:0] seconds_left(input bomb_state_t st, input int ticks);
    if (st != COUNTDOWN) return '0;
    return FUSE_W'((FUSE_TICKS - ticks + TICKS_PER_SEC - 1) / TICKS_PER_SEC);
  endfunction

  // --------------------------------------------------------------------------
  // reference model, one step per rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n || game_over) begin
      m_st    = '{IDLE, IDLE};
      m_ticks = '{0, 0};
      m_prev  = '0;
      m_rise1 = '0;
      m_rise2 = '0;
      foreach (m_tile[a]) m_tile[a] = TILE_EMPTY;  // whole map wiped
    end else begin
      for (int p = 0; p < 2; p++) begin
        case (m_st[p])
          IDLE: if (m_rise2[p]) m_st[p] = PLACE;  // strobes outside idle fall away
          PLACE: begin
            m_addr[p]         = (p == 0) ? tile_of(p0_x, p0_y) : tile_of(p1_x, p1_y);
            m_tile[m_addr[p]] = TILE_BOMB;
            m_ticks[p]        = 0;
            m_st[p]           = COUNTDOWN;
          end
          COUNTDOWN: begin
            if (tick) m_ticks[p]++;
            if (m_ticks[p] == FUSE_TICKS) m_st[p] = EXPLODE;
          end
          default: begin
            m_tile[m_addr[p]] = TILE_EMPTY;  // saved tile, not the current one
            m_st[p]           = IDLE;
          end
        endcase
      end
      m_rise2 = m_rise1;  // rise at edge n acts at edge n+2
      m_rise1 = place_bomb & ~m_prev;
      m_prev  = place_bomb;
    end
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_tile(input tile_t got, input tile_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_addr(input map_addr_t got, input map_addr_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name,
                           input bomb_state_t st);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %b got %b (model %s)", $time, name, exp, got, st.name());
    end
  endtask

  task automatic check_fuse(input logic [FUSE_W-1:0] got, input logic [FUSE_W-1:0] exp,
                            input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  // flags checked every cycle mid-period
  always @(negedge clk) begin
    if (arst_n) begin
      for (int p = 0; p < 2; p++) begin
        check_bit(explode[p], !game_over && (m_st[p] == EXPLODE),
                  $sformatf("explode[%0d]", p), m_st[p]);
        check_bit(busy[p], !game_over && (m_st[p] == PLACE || m_st[p] == COUNTDOWN),
                  $sformatf("busy[%0d]", p), m_st[p]);
        check_fuse((p == 0) ? p0_fuse_left : p1_fuse_left, seconds_left(m_st[p], m_ticks[p]),
                   $sformatf("p%0d_fuse_left", p));
        if (explode[p]) d_expl[p]++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------
  task automatic move_player(input int p);
    pos_x[p] = px_x_t'($unsigned($random(seed)) % X_SPAN);
    pos_y[p] = px_y_t'($unsigned($random(seed)) % Y_SPAN);
    @(posedge clk);
    if (p == 0) begin
      p0_x <= pos_x[0];
      p0_y <= pos_y[0];
    end else begin
      p1_x <= pos_x[1];
      p1_y <= pos_y[1];
    end
  endtask

  task automatic strobe(input logic [1:0] mask);
    @(posedge clk);
    place_bomb <= mask;  // edge k
    @(posedge clk);
    place_bomb <= 2'b00;  // sampled high at k+1
  endtask

  // after strobe: addr set at k+2, reads at k+3..k+6, so 4 tries cover a deferred write
  task automatic poll_tile(input map_addr_t addr, input tile_t want, input int tries);
    @(posedge clk);
    read_addr <= addr;
    @(posedge clk);
    for (int i = 0; i < tries; i++) begin
      @(negedge clk);
      if (read_data == want) break;
    end
    check_tile(read_data, want, $sformatf("read_data[%0d]", addr));
  endtask

  task automatic scan_map(output map_addr_t first_bomb);
    first_bomb = '1;  // none found
    for (int a = 0; a < DEPTH; a++) begin
      @(posedge clk);
      read_addr <= map_addr_t'(a);
      @(posedge clk);
      @(negedge clk);
      check_tile(read_data, m_tile[a], $sformatf("read_data[%0d]", a));
      if (read_data == TILE_BOMB && first_bomb == '1) first_bomb = map_addr_t'(a);
    end
  endtask

  // tick gaps of 1 to 4 cycles, stops early once the DUT has gone quiet
  task automatic send_ticks(input int max_ticks, input bit stop_idle);
    int n;
    n = 0;
    @(negedge clk);
    while (n < max_ticks && !(stop_idle && busy == 2'b00 && explode == 2'b00)) begin
      @(posedge clk);
      tick <= 1'b1;
      @(posedge clk);
      tick <= 1'b0;
      repeat ($unsigned($random(seed)) % 4) @(posedge clk);
      @(negedge clk);
      n++;
    end
    if (stop_idle && (busy != 2'b00 || explode != 2'b00)) begin
      errors++;
      $display("fuse still running after %0d ticks", n);
    end
  endtask

  task automatic place_pair(output map_addr_t a0, output map_addr_t a1);
    move_player(0);
    move_player(1);
    while (tile_of(pos_x[0], pos_y[0]) == tile_of(pos_x[1], pos_y[1])) move_player(1);
    a0 = tile_of(pos_x[0], pos_y[0]);
    a1 = tile_of(pos_x[1], pos_y[1]);
    strobe(2'b11);
    poll_tile(a1, TILE_BOMB, 4);  // player 1 loses the tie, slowest path
    poll_tile(a0, TILE_BOMB, 1);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %-26s %s", tests, name, (errors == err_mark) ? "ok" : "failed");
    err_mark = errors;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    map_addr_t a0;
    map_addr_t a1;
    map_addr_t found;
    int        p;
    seed       = 32'hb1498b9e;
    clk        = 1'b0;
    arst_n     = 1'b0;
    tick       = 1'b0;
    game_over  = 1'b0;
    place_bomb = 2'b00;
    p0_x       = '0;
    p1_x       = '0;
    p0_y       = '0;
    p1_y       = '0;
    read_addr  = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    scan_map(found);
    finish_test("reset map empty");

    for (int i = 0; i < N_RAND; i++) begin
      p = $unsigned($random(seed)) % 2;
      move_player(p);
      a0 = tile_of(pos_x[p], pos_y[p]);
      strobe(p == 0 ? 2'b01 : 2'b10);
      poll_tile(a0, TILE_BOMB, 4);
      scan_map(found);
      check_addr(found, a0, "bomb address");
      exp_expl[p]++;
      send_ticks(FUSE_TICKS + 4, 1'b1);
      check_count(d_expl[p], exp_expl[p], $sformatf("explode count p%0d", p));
    end
    scan_map(found);
    finish_test("random placements");

    move_player(1);
    a1 = tile_of(pos_x[1], pos_y[1]);
    strobe(2'b10);
    poll_tile(a1, TILE_BOMB, 4);
    move_player(1);  // walk off before the fuse ends
    exp_expl[1]++;
    send_ticks(FUSE_TICKS + 4, 1'b1);
    poll_tile(a1, TILE_EMPTY, 1);
    check_count(d_expl[1], exp_expl[1], "explode count p1");
    finish_test("fuse after move");

    move_player(0);
    a0 = tile_of(pos_x[0], pos_y[0]);
    strobe(2'b01);
    poll_tile(a0, TILE_BOMB, 4);
    repeat (2) begin
      move_player(0);
      strobe(2'b01);  // dropped, one bomb per player
      repeat (4) @(posedge clk);
    end
    scan_map(found);
    check_addr(found, a0, "bomb address");
    exp_expl[0]++;
    send_ticks(FUSE_TICKS + 4, 1'b1);
    scan_map(found);
    check_count(d_expl[0], exp_expl[0], "explode count p0");
    finish_test("strobe while busy");

    place_pair(a0, a1);
    scan_map(found);
    exp_expl[0]++;
    exp_expl[1]++;
    send_ticks(FUSE_TICKS + 4, 1'b1);  // both free their tiles in the same cycle
    scan_map(found);
    check_count(d_expl[0], exp_expl[0], "explode count p0");
    check_count(d_expl[1], exp_expl[1], "explode count p1");
    finish_test("simultaneous placements");

    place_pair(a0, a1);
    send_ticks(5, 1'b0);
    @(posedge clk);
    game_over <= 1'b1;
    repeat (2) @(posedge clk);
    game_over <= 1'b0;
    scan_map(found);
    send_ticks(FUSE_TICKS + 4, 1'b0);  // long enough for a stale fuse to fire
    check_count(d_expl[0], exp_expl[0], "explode count p0");
    check_count(d_expl[1], exp_expl[1], "explode count p1");
    finish_test("game over mid fuse");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== files.f ====
rtl/bomb_pkg.sv
rtl/bomb_logic.sv
rtl/map_write_arbiter.sv
rtl/map_mem.sv
rtl/bomb_field.sv
bench/bomb_field_tb.sv

// ==== rtl/bomb_field.sv ====
`timescale 1ns/1ps

// NUM_ROW * NUM_COL must stay at or below 256 tiles
module bomb_field #(
  parameter int NUM_ROW       = 11,
  parameter int NUM_COL       = 19,
  parameter int TILE_PX       = 64,
  parameter int SPRITE_W      = 32,
  parameter int SPRITE_H      = 64,
  parameter int BOMB_TIME     = 3,
  parameter int TICKS_PER_SEC = 4,
  localparam int DEPTH        = NUM_ROW * NUM_COL,
  localparam int FUSE_W       = $clog2(BOMB_TIME + 1)
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                tick,
  input  logic                game_over,
  input  logic [1:0]          place_bomb,  // one bit per player
  input  bomb_pkg::px_x_t     p0_x,
  input  bomb_pkg::px_x_t     p1_x,
  input  bomb_pkg::px_y_t     p0_y,
  input  bomb_pkg::px_y_t     p1_y,
  input  bomb_pkg::map_addr_t read_addr,
  output bomb_pkg::tile_t     read_data,
  output logic [1:0]          explode,
  output logic [1:0]          busy,
  output logic [FUSE_W-1:0]   p0_fuse_left,
  output logic [FUSE_W-1:0]   p1_fuse_left
);
  import bomb_pkg::*;

  map_wr_t wr_p0;   // player 0 to arbiter
  map_wr_t wr_p1;   // player 1 to arbiter
  map_wr_t wr_mem;  // merged write into map

  // --------------------------------------------------------------------------
  // player controllers
  // --------------------------------------------------------------------------
  bomb_logic #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .TILE_PX(TILE_PX), .SPRITE_W(SPRITE_W),
    .SPRITE_H(SPRITE_H), .BOMB_TIME(BOMB_TIME), .TICKS_PER_SEC(TICKS_PER_SEC)
  ) u_bomb_p0 (
    .clk(clk), .arst_n(arst_n), .tick(tick), .game_over(game_over),
    .place_bomb(place_bomb[0]), .player_x(p0_x), .player_y(p0_y),
    .map_wr(wr_p0), .explode(explode[0]), .busy(busy[0]), .fuse_left(p0_fuse_left)
  );

  bomb_logic #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .TILE_PX(TILE_PX), .SPRITE_W(SPRITE_W),
    .SPRITE_H(SPRITE_H), .BOMB_TIME(BOMB_TIME), .TICKS_PER_SEC(TICKS_PER_SEC)
  ) u_bomb_p1 (
    .clk(clk), .arst_n(arst_n), .tick(tick), .game_over(game_over),
    .place_bomb(place_bomb[1]), .player_x(p1_x), .player_y(p1_y),
    .map_wr(wr_p1), .explode(explode[1]), .busy(busy[1]), .fuse_left(p1_fuse_left)
  );

  // shared map write port, player 0 wins a tie
  map_write_arbiter u_arb (
    .clk(clk), .arst_n(arst_n), .wr_a(wr_p0), .wr_b(wr_p1), .wr_out(wr_mem)
  );

  // tile map, cleared on game over
  map_mem #(
    .DEPTH(DEPTH)
  ) u_map (
    .clk(clk), .arst_n(arst_n), .clear(game_over), .wr(wr_mem),
    .read_addr(read_addr), .read_data(read_data)
  );

endmodule

// ==== rtl/bomb_logic.sv ====
`timescale 1ns/1ps

module bomb_logic #(
  parameter int NUM_ROW       = 11,
  parameter int NUM_COL       = 19,
  parameter int TILE_PX       = 64,
  parameter int SPRITE_W      = 32,
  parameter int SPRITE_H      = 64,
  parameter int BOMB_TIME     = 3,  // fuse length in seconds
  parameter int TICKS_PER_SEC = 4,  // game ticks per second
  localparam int FUSE_W       = $clog2(BOMB_TIME + 1)
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              tick,       // game time strobe
  input  logic              game_over,  // level, back to idle
  input  logic              place_bomb, // raw button level
  input  bomb_pkg::px_x_t   player_x,
  input  bomb_pkg::px_y_t   player_y,
  output bomb_pkg::map_wr_t map_wr,
  output logic              explode,
  output logic              busy,
  output logic [FUSE_W-1:0] fuse_left   // whole seconds left
);
  import bomb_pkg::*;

  localparam int TICK_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

  logic              place_s1;    // first sync stage
  logic              place_s2;    // second sync stage
  logic              place_prev;  // for rising edge
  logic              place_pulse;
  bomb_state_t       st;
  bomb_state_t       nst;
  logic [TICK_W-1:0] tick_cnt;    // ticks within current second
  logic [FUSE_W-1:0] sec_left;
  logic              sec_done;
  px_x_t             centre_x;
  px_y_t             centre_y;
  px_x_t             tile_col;
  px_y_t             tile_row;
  map_addr_t         cur_addr;    // tile under the sprite now
  map_addr_t         saved_addr;  // tile that holds the bomb
  logic              live;

  // --------------------------------------------------------------------------
  // place strobe sync and edge detect
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      place_s1   <= 1'b0;
      place_s2   <= 1'b0;
      place_prev <= 1'b0;
    end else if (game_over) begin
      place_s1   <= 1'b0;
      place_s2   <= 1'b0;
      place_prev <= 1'b0;
    end else begin
      place_s1   <= place_bomb;
      place_s2   <= place_s1;
      place_prev <= place_s2;
    end
  end

  // one bomb at a time, strobes outside idle are dropped
  assign place_pulse = place_s2 & ~place_prev & (st == IDLE);

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  assign sec_done = (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)        st <= IDLE;
    else if (game_over) st <= IDLE;
    else                st <= nst;
  end

  always_comb begin
    nst = st;
    case (st)
      IDLE:      if (place_pulse) nst = PLACE;
      PLACE:     nst = COUNTDOWN;
      COUNTDOWN: if (tick && sec_done && (sec_left == FUSE_W'(1))) nst = EXPLODE;
      EXPLODE:   nst = IDLE;
      default:   nst = IDLE;
    endcase
  end

  // fuse counters, ticks nested inside seconds
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
      sec_left <= '0;
    end else if (game_over) begin
      tick_cnt <= '0;
      sec_left <= '0;
    end else begin
      case (st)
        PLACE: begin
          tick_cnt <= '0;
          sec_left <= FUSE_W'(BOMB_TIME); // full fuse
        end
        COUNTDOWN: begin
          if (tick) begin
            if (sec_done) begin
              tick_cnt <= '0;
              sec_left <= sec_left - 1'b1; // reaches 0 on the last tick
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        default: begin
          tick_cnt <= '0;
          sec_left <= '0;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // tile address from sprite centre
  // --------------------------------------------------------------------------
  always_comb begin
    centre_x = player_x + px_x_t'(SPRITE_W / 2);
    centre_y = player_y + px_y_t'(SPRITE_H / 2);
    tile_col = px_x_t'(centre_x / TILE_PX);
    tile_row = px_y_t'(centre_y / TILE_PX);
    if (tile_col >= px_x_t'(NUM_COL)) tile_col = px_x_t'(NUM_COL - 1); // keep inside map
    if (tile_row >= px_y_t'(NUM_ROW)) tile_row = px_y_t'(NUM_ROW - 1);
    cur_addr = map_addr_t'(tile_row * NUM_COL + tile_col);
  end

  always_ff @(posedge clk) begin
    if (st == PLACE) saved_addr <= cur_addr; // freed later even if player moved
  end

  // outputs
  assign live        = ~game_over;
  assign explode     = live & (st == EXPLODE);
  assign busy        = live & ((st == PLACE) | (st == COUNTDOWN));
  assign map_wr.en   = live & ((st == PLACE) | (st == EXPLODE));
  assign map_wr.addr = (st == EXPLODE) ? saved_addr : cur_addr;
  assign map_wr.data = (st == EXPLODE) ? TILE_EMPTY : TILE_BOMB;
  assign fuse_left   = sec_left;

endmodule

// ==== rtl/bomb_pkg.sv ====
package bomb_pkg;

  // --------------------------------------------------------------------------
  // widths with a meaning
  // --------------------------------------------------------------------------
  typedef logic [10:0] px_x_t;     // sprite top-left x in pixels
  typedef logic [9:0]  px_y_t;     // sprite top-left y in pixels
  typedef logic [7:0]  map_addr_t; // linear tile index, up to 256 tiles

  // map cell content
  // codes 1 and 2 are kept free for walls
  typedef enum logic [1:0] {
    TILE_EMPTY = 2'd0,
    TILE_BOMB  = 2'd3
  } tile_t;

  // --------------------------------------------------------------------------
  // map write, one cycle pulse on en
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic      en;   // write strobe
    map_addr_t addr; // target tile
    tile_t     data; // new cell content
  } map_wr_t;

  // bomb controller FSM
  typedef enum logic [1:0] {
    IDLE      = 2'd0, // waiting for a place strobe
    PLACE     = 2'd1, // bomb tile written this cycle
    COUNTDOWN = 2'd2, // fuse running on game ticks
    EXPLODE   = 2'd3  // explode pulse and tile freed
  } bomb_state_t;

endpackage

// ==== rtl/map_mem.sv ====
`timescale 1ns/1ps

module map_mem #(
  parameter int DEPTH = 209  // tiles in the map
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                clear,      // wipe whole map
  input  bomb_pkg::map_wr_t   wr,
  input  bomb_pkg::map_addr_t read_addr,
  output bomb_pkg::tile_t     read_data
);
  import bomb_pkg::*;

  tile_t cells [DEPTH];

  // --------------------------------------------------------------------------
  // write port
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      foreach (cells[i]) cells[i] <= TILE_EMPTY;  // map starts empty
    end else if (clear) begin
      foreach (cells[i]) cells[i] <= TILE_EMPTY;  // clear beats any write
    end else if (wr.en && (int'(wr.addr) < DEPTH)) begin
      cells[wr.addr] <= wr.data;
    end
  end

  // registered read for the renderer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      read_data <= TILE_EMPTY;
    end else if (int'(read_addr) < DEPTH) begin
      read_data <= cells[read_addr];
    end else begin
      read_data <= TILE_EMPTY;  // off the map reads empty
    end
  end

endmodule

// ==== rtl/map_write_arbiter.sv ====
`timescale 1ns/1ps

module map_write_arbiter (
  input  logic              clk,
  input  logic              arst_n,
  input  bomb_pkg::map_wr_t wr_a,  // player 0, wins a tie
  input  bomb_pkg::map_wr_t wr_b,  // player 1
  output bomb_pkg::map_wr_t wr_out
);
  import bomb_pkg::*;

  logic    pending;  // held write waiting to drain
  map_wr_t held_wr;  // the write that lost
  logic    b_loses;

  // --------------------------------------------------------------------------
  // priority: held write, then a, then b
  // --------------------------------------------------------------------------
  always_comb begin
    if (pending) begin
      wr_out = held_wr;  // drain first
    end else if (wr_a.en) begin
      wr_out = wr_a;
    end else begin
      wr_out = wr_b;     // b or nothing, en tells
    end
  end

  // b only loses on a tie with a or against a drain
  // write spacing keeps a off the port while pending
  assign b_loses = wr_b.en & (pending | wr_a.en);

  // one entry hold
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
    end else begin
      pending <= b_loses;  // clears itself after one drain cycle
    end
  end

  always_ff @(posedge clk) begin
    if (b_loses) held_wr <= wr_b;
  end

endmodule
